//--- common/panelPkg.sv
// Constants assume a 100 MHz CLK and a 640x480 screen, and the tone period is kept short for simulation
`default_nettype none

package panelPkg;

	////////////////////////////////////////
	// Video timing
	localparam int pixelDiv = 4;          // CLK cycles per pixel, 25 MHz pixels
	localparam int hVisible = 640;        // Active pixels per line
	localparam int hFront   = 16;
	localparam int hSync    = 96;         // Sync pulse width in pixels
	localparam int hBack    = 48;
	localparam int hTotal   = hVisible + hFront + hSync + hBack; // 800 pixels
	localparam int vVisible = 480;        // Active lines per frame
	localparam int vFront   = 10;
	localparam int vSync    = 2;          // Sync pulse width in lines
	localparam int vBack    = 33;
	localparam int vTotal   = vVisible + vFront + vSync + vBack; // 525 lines

	// Key-code band at top of screen
	localparam int keyBandLines = 16;     // Band height in lines
	localparam int keyBandWidth = 80;     // One bit column, eight columns fill the line

	////////////////////////////////////////
	// Processor port map
	localparam logic [7:0] keyPortId   = 8'h10; // Read latest key code
	localparam logic [7:0] colorLowId  = 8'h20; // Background colour bits 7..0
	localparam logic [7:0] colorHighId = 8'h21; // Background colour bits 11..8

	// Keyboard
	localparam logic [7:0] breakCode    = 8'hF0; // Key release prefix
	localparam int         ps2IdleLimit = 4096;  // Idle cycles before a partial frame is dropped

	// Alarm tone
	localparam int toneHalfPeriod = 500;  // CLK cycles per speaker half period

endpackage

`default_nettype wire

//--- common/ps2FrameIf.sv
// Fields are valid in the frameDone cycle and held until the next frame ends
`default_nettype none

interface ps2FrameIf;

	logic [7:0] frameData;   // Data byte of the frame, bit 0 first on the wire
	logic       frameDone;   // One-cycle pulse per complete frame
	logic       parityOk;    // Odd parity held
	logic       framingOk;   // Start bit low and stop bit high

	// Receiver side
	modport rx (
		output frameData,
		output frameDone,
		output parityOk,
		output framingOk
	);

	// Translator side
	modport tr (
		input frameData,
		input frameDone,
		input parityOk,
		input framingOk
	);

endinterface

`default_nettype wire

//--- keyboard/ps2Receiver.sv
// Receive only with idle-high lines, and CLK must run far faster than the keyboard clock
`default_nettype none

module ps2Receiver
	import panelPkg::*;
(
	input  wire   CLK,     // System clock
	input  wire   rst,     // Synchronous reset, active high
	input  wire   ps2c,    // Keyboard clock, asynchronous
	input  wire   ps2d,    // Keyboard data, asynchronous
	ps2FrameIf.rx frame    // Completed frame towards translator
);

	logic [1:0]  clkSync;    // Two-flop synchroniser for ps2c
	logic [1:0]  datSync;    // Two-flop synchroniser for ps2d
	logic        clkPrev;    // Synced clock one cycle back
	logic        fallEdge;   // Keyboard clock went low
	logic        lastBit;    // Stop bit being sampled now
	logic [9:0]  shiftReg;   // First ten bits of the frame
	logic [10:0] fullFrame;  // Whole frame incl. bit on the line
	logic [3:0]  bitCnt;     // Bits sampled so far, 0..10
	logic [$clog2(ps2IdleLimit)-1:0] idleCnt; // Cycles since last edge

	////////////////////////////////////////
	// Synchronise and detect edges
	always_ff @(posedge CLK) begin
		if (rst) begin
			clkSync <= 2'b11;    // Lines idle high
			datSync <= 2'b11;
			clkPrev <= 1'b1;
		end else begin
			clkSync <= {clkSync[0], ps2c};
			datSync <= {datSync[0], ps2d};
			clkPrev <= clkSync[1];
		end
	end

	assign fallEdge  = clkPrev & ~clkSync[1];           // Third cycle after the pin edge
	assign lastBit   = fallEdge && (bitCnt == 4'd10);
	assign fullFrame = {datSync[1], shiftReg};          // Start bit ends up at bit 0

	////////////////////////////////////////
	// Bit counter with watchdog
	always_ff @(posedge CLK) begin
		if (rst) begin
			bitCnt  <= '0;
			idleCnt <= '0;
		end else if (fallEdge) begin
			idleCnt <= '0;
			bitCnt  <= lastBit ? 4'd0 : bitCnt + 4'd1;
		end else if (bitCnt == 4'd0) begin
			idleCnt <= '0;                                // Nothing pending
		end else if (int'(idleCnt) == ps2IdleLimit - 1) begin
			bitCnt  <= '0;                                // Stale partial frame dropped
			idleCnt <= '0;
		end else begin
			idleCnt <= idleCnt + 1'b1;
		end
	end

	// LSB first so shift right
	always_ff @(posedge CLK) begin
		if (fallEdge)
			shiftReg <= fullFrame[10:1];
	end

	////////////////////////////////////////
	// Frame checks and output
	always_ff @(posedge CLK) begin
		if (rst)
			frame.frameDone <= 1'b0;
		else
			frame.frameDone <= lastBit;                   // One cycle after the stop bit
	end

	always_ff @(posedge CLK) begin
		if (lastBit) begin
			frame.frameData <= fullFrame[8:1];
			frame.parityOk  <= ^fullFrame[9:1];           // Data plus parity must be odd
			frame.framingOk <= ~fullFrame[0] & fullFrame[10];
		end
	end

	// Counter wraps at the stop bit and never runs past it
	bitCntRange : assert property (@(posedge CLK) disable iff (rst) bitCnt <= 4'd10)
		else $error("ps2Receiver bit counter out of range %0d", bitCnt);

endmodule

`default_nettype wire

//--- keyboard/scanTranslator.sv
// Keeps only the newest make code, so a frame not yet read by the processor is overwritten
`default_nettype none

module scanTranslator
	import panelPkg::*;
(
	input  wire        CLK,       // System clock
	input  wire        rst,       // Synchronous reset, active high
	ps2FrameIf.tr      frame,     // Frames from receiver
	input  wire        readReq,   // Processor read request
	input  wire  [7:0] portId,    // Processor port address
	output logic [7:0] keyCode,   // Latest make code, to display
	output logic [7:0] keyOut     // Key code as read by processor
);

	logic goodFrame;     // Complete frame that passed both checks
	logic isBreak;       // Frame carries the release prefix
	logic breakPending;  // Next good frame is a released key
	logic keyRead;       // Processor reads the key port

	////////////////////////////////////////
	// Frame filter
	assign goodFrame = frame.frameDone & frame.parityOk & frame.framingOk;
	assign isBreak   = (frame.frameData == breakCode);

	always_ff @(posedge CLK) begin
		if (rst) begin
			keyCode      <= '0;
			breakPending <= 1'b0;
		end else if (goodFrame) begin
			if (breakPending)
				breakPending <= 1'b0;          // Released key code swallowed
			else if (isBreak)
				breakPending <= 1'b1;
			else
				keyCode <= frame.frameData;    // New make code
		end
	end

	////////////////////////////////////////
	// Processor read port
	assign keyRead = readReq && (portId == keyPortId);

	always_ff @(posedge CLK) begin
		if (rst)
			keyOut <= '0;
		else if (keyRead)
			keyOut <= keyCode;                 // Value before this edge
	end

	// Code after a break prefix must not reach the display
	breakHoldsKey : assert property (
		@(posedge CLK) disable iff (rst) breakPending |=> $stable(keyCode)
	) else $error("scanTranslator keyCode changed while a break was pending");

endmodule

`default_nettype wire

//--- display/vgaTiming.sv
// Fixed 640x480 timing at pixelDiv CLK cycles per pixel, syncs active low and registered
`default_nettype none

module vgaTiming
	import panelPkg::*;
(
	input  wire        CLK,        // System clock
	input  wire        rst,        // Synchronous reset, active high
	output logic       pixelTick,  // High once every pixelDiv cycles
	output logic [9:0] pixelX,     // Horizontal position
	output logic [9:0] pixelY,     // Vertical position
	output logic       visible,    // Inside active area
	output logic       hs,         // Horizontal sync, active low
	output logic       vs          // Vertical sync, active low
);

	logic [$clog2(pixelDiv)-1:0] divCnt;  // Pixel clock divider
	logic [9:0] hCnt;                      // Pixel within line
	logic [9:0] vCnt;                      // Line within frame
	logic       lineEnd;                   // Last pixel of line
	logic       hSyncOn;                   // Inside horizontal pulse
	logic       vSyncOn;                   // Inside vertical pulse

	////////////////////////////////////////
	// Pixel divider
	assign pixelTick = (int'(divCnt) == pixelDiv - 1);

	always_ff @(posedge CLK) begin
		if (rst)
			divCnt <= '0;
		else if (pixelTick)
			divCnt <= '0;
		else
			divCnt <= divCnt + 1'b1;
	end

	////////////////////////////////////////
	// Line and frame counters
	assign lineEnd = (int'(hCnt) == hTotal - 1);

	always_ff @(posedge CLK) begin
		if (rst) begin
			hCnt <= '0;
			vCnt <= '0;
		end else if (pixelTick) begin
			if (lineEnd) begin
				hCnt <= '0;
				vCnt <= (int'(vCnt) == vTotal - 1) ? 10'd0 : vCnt + 10'd1;
			end else begin
				hCnt <= hCnt + 10'd1;
			end
		end
	end

	// Position decode
	assign hSyncOn = (int'(hCnt) >= hVisible + hFront) && (int'(hCnt) < hVisible + hFront + hSync);
	assign vSyncOn = (int'(vCnt) >= vVisible + vFront) && (int'(vCnt) < vVisible + vFront + vSync);
	assign visible = (int'(hCnt) < hVisible) && (int'(vCnt) < vVisible);
	assign pixelX  = hCnt;
	assign pixelY  = vCnt;

	// One cycle behind counters, same as rgb
	always_ff @(posedge CLK) begin
		if (rst) begin
			hs <= 1'b1;
			vs <= 1'b1;
		end else begin
			hs <= ~hSyncOn;
			vs <= ~vSyncOn;
		end
	end

	hCntRange : assert property (@(posedge CLK) disable iff (rst) int'(hCnt) < hTotal)
		else $error("vgaTiming horizontal count %0d past line end", hCnt);

endmodule

`default_nettype wire

//--- display/displayRegs.sv
// Expects counters that move on pixelTick, and rgb follows them one CLK later like the syncs
`default_nettype none

module displayRegs
	import panelPkg::*;
(
	input  wire         CLK,          // System clock
	input  wire         rst,          // Synchronous reset, active high
	input  wire         pixelTick,    // Counters advance on this
	input  wire         writeStrobe,  // Processor write strobe
	input  wire   [7:0] portId,       // Processor port address
	input  wire   [7:0] outPort,      // Processor write data
	input  wire   [7:0] keyCode,      // Latest make code
	input  wire   [9:0] pixelX,       // Horizontal position
	input  wire   [9:0] pixelY,       // Vertical position
	input  wire         visible,      // Inside active area
	output logic [11:0] rgb           // Pixel colour, 4 bits per channel
);

	logic [11:0] bgColor;    // Background colour register
	logic        pixelLoad;  // Counters just moved
	logic [2:0]  bandCol;    // Bit column under the beam
	logic        inBand;     // Inside key-code band
	logic        keyBit;     // Key bit for this column
	logic [11:0] pixelColor; // Colour before the output register

	////////////////////////////////////////
	// Colour register writes
	always_ff @(posedge CLK) begin
		if (rst) begin
			bgColor <= '0;
		end else if (writeStrobe) begin
			if (portId == colorLowId)
				bgColor[7:0] <= outPort;
			if (portId == colorHighId)
				bgColor[11:8] <= outPort[3:0];    // Upper nibble ignored
		end
	end

	////////////////////////////////////////
	// Pixel colour
	assign bandCol = 3'(pixelX / 10'(keyBandWidth));   // 0..7 across the line
	assign inBand  = (int'(pixelY) < keyBandLines);
	assign keyBit  = keyCode[3'd7 - bandCol];          // MSB on the left

	always_comb begin
		if (!visible)
			pixelColor = 12'h000;                         // Blank in porches and sync
		else if (inBand)
			pixelColor = keyBit ? 12'hFFF : 12'h000;
		else
			pixelColor = bgColor;
	end

	// Load once per pixel, first cycle after counters move
	always_ff @(posedge CLK) begin
		if (rst)
			pixelLoad <= 1'b1;                            // Pixel 0,0 loads right after reset
		else
			pixelLoad <= pixelTick;
	end

	always_ff @(posedge CLK) begin
		if (rst)
			rgb <= '0;
		else if (pixelLoad)
			rgb <= pixelColor;
	end

	strobeKnown : assert property (@(posedge CLK) disable iff (rst) !$isunknown(writeStrobe))
		else $error("displayRegs writeStrobe unknown");

endmodule

`default_nettype wire

//--- logic/alarmTone.sv
// Single square tone only, and every alarm restarts the tone from the same phase
`default_nettype none

module alarmTone
	import panelPkg::*;
(
	input  wire  CLK,      // System clock
	input  wire  rst,      // Synchronous reset, active high
	input  wire  alarm,    // Tone enable
	output logic speaker   // Square wave out
);

	logic [$clog2(toneHalfPeriod)-1:0] halfCnt;  // Cycles into current half period
	logic halfEnd;                                // Half period complete

	assign halfEnd = (int'(halfCnt) == toneHalfPeriod - 1);

	////////////////////////////////////////
	// Half-period counter and output
	always_ff @(posedge CLK) begin
		if (rst) begin
			halfCnt <= '0;
			speaker <= 1'b0;
		end else if (!alarm) begin
			halfCnt <= '0;         // Silent and phase cleared
			speaker <= 1'b0;
		end else if (halfEnd) begin
			halfCnt <= '0;
			speaker <= ~speaker;   // Toggle each half period
		end else begin
			halfCnt <= halfCnt + 1'b1;
		end
	end

endmodule

`default_nettype wire

//--- logic/clockPanelTop.sv
// One shared clock, the processor side drives the ports, and no data goes back to the keyboard
`default_nettype none

module clockPanelTop (
	input  wire         CLK,          // System clock, 100 MHz
	input  wire         rst,          // Synchronous reset, active high
	input  wire   [7:0] portId,       // Processor port address
	input  wire         writeStrobe,  // Processor write strobe
	input  wire   [7:0] outPort,      // Processor write data
	input  wire         alarm,        // Alarm active
	input  wire         ps2c,         // Keyboard clock
	input  wire         ps2d,         // Keyboard data
	input  wire         readReq,      // Processor read request
	output logic [11:0] rgb,          // VGA colour
	output logic        hs,           // VGA horizontal sync
	output logic        vs,           // VGA vertical sync
	output logic  [7:0] keyOut,       // Key code to processor
	output logic        speaker       // Speaker pin
);

	logic [7:0] keyCode;    // Translator to display
	logic [9:0] pixelX;
	logic [9:0] pixelY;
	logic       visible;
	logic       pixelTick;

	ps2FrameIf frameBus ();  // Receiver to translator

	////////////////////////////////////////
	// Keyboard path
	ps2Receiver i_ps2Receiver (
		.CLK   (CLK),
		.rst   (rst),
		.ps2c  (ps2c),
		.ps2d  (ps2d),
		.frame (frameBus.rx)
	);

	scanTranslator i_scanTranslator (
		.CLK     (CLK),
		.rst     (rst),
		.frame   (frameBus.tr),
		.readReq (readReq),
		.portId  (portId),
		.keyCode (keyCode),
		.keyOut  (keyOut)
	);

	////////////////////////////////////////
	// Display path
	vgaTiming i_vgaTiming (
		.CLK       (CLK),
		.rst       (rst),
		.pixelTick (pixelTick),
		.pixelX    (pixelX),
		.pixelY    (pixelY),
		.visible   (visible),
		.hs        (hs),
		.vs        (vs)
	);

	displayRegs i_displayRegs (
		.CLK         (CLK),
		.rst         (rst),
		.pixelTick   (pixelTick),
		.writeStrobe (writeStrobe),
		.portId      (portId),
		.outPort     (outPort),
		.keyCode     (keyCode),
		.pixelX      (pixelX),
		.pixelY      (pixelY),
		.visible     (visible),
		.rgb         (rgb)
	);

	// Alarm tone, enabled rather than clock gated
	alarmTone i_alarmTone (
		.CLK     (CLK),
		.rst     (rst),
		.alarm   (alarm),
		.speaker (speaker)
	);

endmodule

`default_nettype wire

//--- tests/tbClockPanel.sv
// Runs keyboard, picture and alarm phases in turn, so keyCode stays fixed while pixels are checked
`default_nettype none

module tbClockPanel
	import panelPkg::*;
();

	localparam int kbHalf      = 20;     // CLK cycles per keyboard clock half, 40 per bit
	localparam int numRounds   = 24;     // Key rounds
	localparam int numBursts   = 6;      // Alarm bursts
	localparam int lineLen     = hVisible + hFront + hSync + hBack;  // Pixels per line
	localparam int frameLines  = vVisible + vFront + vSync + vBack;  // Lines per frame
	localparam int lineCycles  = lineLen * pixelDiv;                 // CLK cycles per line
	localparam int frameCycles = lineCycles * frameLines;
	localparam int ps2Cycles   = 11 * 2 * kbHalf + kbHalf;           // Frame plus idle gap
	localparam longint limitCycles = 2 * frameCycles + numRounds * (2 * ps2Cycles + 8)
		+ numBursts * 3700 + 20000;                                   // Margin included

	logic        CLK;
	logic        rst;
	logic [7:0]  portId;
	logic        writeStrobe;
	logic [7:0]  outPort;
	logic        alarm;
	logic        ps2c;
	logic        ps2d;
	logic        readReq;
	logic [11:0] rgb;
	logic        hs;
	logic        vs;
	logic [7:0]  keyOut;
	logic        speaker;

	// Reference models
	logic [7:0]  modelKey   = 8'h00;  // Expected keyCode
	logic [7:0]  expKeyOut  = 8'h00;  // Last value read at keyPortId
	logic        breakPend  = 1'b0;
	logic [11:0] modelColor = 12'h000;

	// Monitor state
	logic alarmAtEdge = 1'b0;   // Inputs as seen at the last rising edge
	logic rstAtEdge   = 1'b1;
	logic pictureOn    = 1'b0;
	logic pictureArmed = 1'b0;  // Pixel position known with new colour
	int   checkedFrames = 0;
	int   cycleNo = 0;
	int   lastHsFall = 0;
	int   lastVsFall = 0;
	logic hsSeen = 1'b0;
	logic vsSeen = 1'b0;
	logic hsPrev = 1'b1;
	logic vsPrev = 1'b1;
	logic spkPrev = 1'b0;
	logic toneStarted = 1'b0;
	int   toneCnt = 0;          // Cycles since alarm rise or last toggle

	clockPanelTop i_dut (
		.CLK (CLK), .rst (rst), .portId (portId), .writeStrobe (writeStrobe),
		.outPort (outPort), .alarm (alarm), .ps2c (ps2c), .ps2d (ps2d),
		.readReq (readReq), .rgb (rgb), .hs (hs), .vs (vs), .keyOut (keyOut),
		.speaker (speaker)
	);

	initial CLK = 1'b0;
	always #50 CLK = ~CLK;

	always @(posedge CLK) begin
		alarmAtEdge <= alarm;
		rstAtEdge   <= rst;
	end

	////////////////////////////////////////
	// Helpers
	task automatic stopOnError(input string what);
		$display("%s", what);
		$display("Regression failed");
		$fatal(1);
	endtask

	task automatic reportMismatch(input string sig, input logic [31:0] got, input logic [31:0] exp);
		stopOnError($sformatf("mismatch at time %0t: %s is %0h, expected %0h", $time, sig, got, exp));
	endtask

	task automatic waitCycles(input int n);
		repeat (n) @(negedge CLK);
	endtask

	// Break prefix swallows the next good code, bad parity frames vanish
	task automatic updateKeyModel(input logic [7:0] code, input logic corrupt);
		if (!corrupt) begin
			if (breakPend)
				breakPend = 1'b0;
			else if (code == breakCode)
				breakPend = 1'b1;
			else
				modelKey = code;
		end
	endtask

	// Start, eight data bits LSB first, odd parity, stop
	task automatic sendFrame(input logic [7:0] data, input logic corrupt);
		logic [10:0] bits;
		bits = {1'b1, (~^data) ^ corrupt, data, 1'b0};
		for (int b = 0; b <= 10; b++) begin
			ps2d = bits[b];          // Set while keyboard clock high
			waitCycles(kbHalf);
			ps2c = 1'b0;
			waitCycles(kbHalf);
			ps2c = 1'b1;
		end
		ps2d = 1'b1;
		waitCycles(kbHalf);          // Frame long decoded by now
		updateKeyModel(data, corrupt);
	endtask

	task automatic readKey(input logic [7:0] id);
		portId  = id;
		readReq = 1'b1;
		@(negedge CLK);
		readReq = 1'b0;
		if (id == keyPortId)
			expKeyOut = modelKey;
		assert (keyOut == expKeyOut) else reportMismatch("keyOut", keyOut, expKeyOut);
	endtask

	task automatic writeColor(input logic [7:0] id, input logic [7:0] data);
		portId      = id;
		outPort     = data;
		writeStrobe = 1'b1;
		@(negedge CLK);
		writeStrobe = 1'b0;
		if (id == colorLowId)
			modelColor[7:0] = data;
		else if (id == colorHighId)
			modelColor[11:8] = data[3:0];   // Upper nibble dropped
	endtask

	function automatic logic [11:0] expectedPixel(input int x, input int y);
		int col;
		col = x / keyBandWidth;
		if (x >= hVisible || y >= vVisible)
			return 12'h000;
		if (y < keyBandLines)
			return modelKey[7 - col] ? 12'hFFF : 12'h000;   // MSB leftmost
		return modelColor;
	endfunction

	////////////////////////////////////////
	// Video monitor
	always @(negedge CLK) begin
		int p;
		int x;
		int y;
		logic expHs;
		if (!rstAtEdge) begin
			cycleNo = cycleNo + 1;
			if (!hs || !vs)
				assert (rgb == 12'h000) else reportMismatch("rgb during sync", rgb, 0);
			if (hsPrev && !hs) begin
				if (hsSeen)
					assert (cycleNo - lastHsFall == lineCycles)
						else reportMismatch("hs period", cycleNo - lastHsFall, lineCycles);
				if (vsSeen)   // hs must fall at pixel 656 of the tracked line
					assert (((cycleNo - lastVsFall) / pixelDiv) % lineLen == hVisible + hFront)
						else stopOnError("hs fell at the wrong pixel position");
				lastHsFall = cycleNo;
				hsSeen = 1'b1;
			end
			if (!hsPrev && hs)
				assert (cycleNo - lastHsFall == hSync * pixelDiv)
					else reportMismatch("hs low time", cycleNo - lastHsFall, hSync * pixelDiv);
			if (vsPrev && !vs) begin
				if (vsSeen)
					assert (cycleNo - lastVsFall == frameCycles)
						else reportMismatch("vs period", cycleNo - lastVsFall, frameCycles);
				lastVsFall = cycleNo;
				vsSeen = 1'b1;
				if (pictureArmed)
					checkedFrames = checkedFrames + 1;
				if (pictureOn)
					pictureArmed = 1'b1;
			end
			if (!vsPrev && vs)
				assert (cycleNo - lastVsFall == vSync * lineCycles)
					else reportMismatch("vs low time", cycleNo - lastVsFall, vSync * lineCycles);
			if (pictureArmed) begin
				p = (cycleNo - lastVsFall) / pixelDiv;            // vs falls at pixel 0 of line 490
				x = p % lineLen;
				y = (vVisible + vFront + p / lineLen) % frameLines;
				assert (rgb == expectedPixel(x, y)) else reportMismatch("rgb", rgb, expectedPixel(x, y));
				expHs = !(x >= hVisible + hFront && x < hVisible + hFront + hSync);
				assert (hs == expHs) else reportMismatch("hs", hs, expHs);
			end
			hsPrev = hs;
			vsPrev = vs;
		end
	end

	////////////////////////////////////////
	// Tone monitor
	always @(negedge CLK) begin
		if (!rstAtEdge) begin
			if (!alarmAtEdge) begin
				assert (speaker == 1'b0) else reportMismatch("speaker", speaker, 0);
				toneStarted = 1'b0;
				toneCnt = 0;
			end else begin
				toneCnt = toneCnt + 1;
				if (speaker !== spkPrev) begin
					if (toneStarted) begin
						assert (toneCnt == toneHalfPeriod)
							else reportMismatch("speaker half period", toneCnt, toneHalfPeriod);
					end else begin
						assert (speaker == 1'b1) else stopOnError("speaker did not start with a rise");
					end
					toneStarted = 1'b1;
					toneCnt = 0;
				end else begin
					assert (toneCnt <= toneHalfPeriod) else stopOnError("speaker missed a toggle");
				end
			end
			spkPrev = speaker;
		end
	end

	// Watchdog
	initial begin
		#(limitCycles * 100);
		stopOnError("timeout, the run did not finish in the expected time");
	end

	////////////////////////////////////////
	// Stimulus
	initial begin
		logic [7:0] code;
		logic       corrupt;
		logic [7:0] otherPort;
		void'($urandom(83144));
		rst = 1'b1;
		portId = 8'h00;
		writeStrobe = 1'b0;
		outPort = 8'h00;
		alarm = 1'b0;
		ps2c = 1'b1;              // Keyboard lines idle high
		ps2d = 1'b1;
		readReq = 1'b0;
		repeat (2) @(posedge CLK);  // Two reset cycles
		@(negedge CLK);
		rst = 1'b0;
		@(negedge CLK);

		for (int i = 0; i < numRounds; i++) begin
			code    = 8'($urandom);
			corrupt = (i > 0) && ($urandom % 4 == 0);
			if (i % 5 == 2 || $urandom % 6 == 0)
				sendFrame(breakCode, 1'b0);
			sendFrame(code, corrupt);
			otherPort = 8'($urandom);
			if (otherPort == keyPortId)
				otherPort = otherPort + 8'd1;
			readKey(otherPort);     // keyOut must hold
			readKey(keyPortId);
		end

		writeColor(colorLowId, 8'($urandom));
		writeColor(colorHighId, 8'($urandom));
		writeColor(8'h33, 8'($urandom));   // Foreign port, no effect
		pictureOn = 1'b1;
		wait (checkedFrames >= 1);

		for (int b = 0; b < numBursts; b++) begin
			alarm = 1'b1;
			waitCycles(600 + $urandom % 3000);
			alarm = 1'b0;
			waitCycles(20 + $urandom % 50);
		end
		$display("Regression passed");
		$finish;
	end

endmodule

`default_nettype wire

//--- list.f
common/panelPkg.sv
common/ps2FrameIf.sv
keyboard/ps2Receiver.sv
keyboard/scanTranslator.sv
display/vgaTiming.sv
display/displayRegs.sv
logic/alarmTone.sv
logic/clockPanelTop.sv
tests/tbClockPanel.sv
